//--- hdl/scaler_consts.svh
// Widths, register map and reset values; GAIN_FRAC must stay below GAIN_W
`ifndef SCALER_CONSTS_SVH
`define SCALER_CONSTS_SVH

// Stream sample width, signed
`define SAMPLE_W 16
// Unsigned gain, Q4.4 fixed point
`define GAIN_W 8
`define GAIN_FRAC 4

// APB bus widths
`define APB_AW 8
`define APB_DW 32

// Transfer counters, wrap around
`define CNT_W 32

// Register byte offsets
`define REG_CTRL 8'h00
`define REG_GAIN 8'h04
`define REG_OFFSET 8'h08
`define REG_IN_COUNT 8'h0C
`define REG_OUT_COUNT 8'h10
`define REG_FILL 8'h14

// Configuration after reset, gain 16 is unity
`define RST_GAIN 16
`define RST_OFFSET 0

`endif

//--- hdl/scaler_pkg.sv
// Shared types of the scaler; widths come from scaler_consts.svh
`include "scaler_consts.svh"

package scaler_pkg;

	// Signed stream sample
	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	// Unsigned fixed point gain
	typedef logic [`GAIN_W-1:0] gain_t;

	// Stream transfer counter
	typedef logic [`CNT_W-1:0] count_t;

	// Whole pipeline occupancy, 0 to 5
	typedef logic [2:0] fill_t;

	// One skid register occupancy, 0 to 2
	typedef logic [1:0] occ_t;

	// APB address and data words
	typedef logic [`APB_AW-1:0] apb_addr_t;
	typedef logic [`APB_DW-1:0] apb_data_t;

	// Settings the transform stage works from
	typedef struct packed {
		logic enable;
		gain_t gain;
		sample_t offset;
	} scaler_cfg_t;

	// Master side of an APB access
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

endpackage

//--- hdl/axis_register.sv
// Two-entry skid register; all outputs registered, size counts beats held inside
`timescale 1ns/1ps

module axis_register
	import scaler_pkg::*;
#(
	parameter int WIDTH = 8
)
(
	input logic clock,
	input logic resetn,
	output occ_t size,
	input logic [WIDTH-1:0] idata,
	input logic ivalid,
	output logic iready,
	output logic [WIDTH-1:0] odata,
	output logic ovalid,
	input logic oready
);

	// Holds a beat accepted while the output stalls
	logic [WIDTH-1:0] buffer;

	// Occupancy from the flag pair
	// iready and !ovalid means empty, !iready means both slots used
	assign size = {!iready, iready && ovalid};

	// Handshake flags
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			ovalid <= 1'b0;
			iready <= 1'b1;
		end
		else
		begin
			// Output stays full while stalled or while the buffer has data
			ovalid <= (ovalid && !oready) || !iready || ivalid;
			// Buffer frees up once the output moves or nothing comes in
			iready <= !ovalid || oready || (iready && !ivalid);
		end
	end

	// Payload registers
	always_ff @(posedge clock)
	begin
		// Output word advances unless stalled
		if (!ovalid || oready)
			odata <= iready ? idata : buffer;
		// Capture input while the buffer is free
		if (iready)
			buffer <= idata;
	end

endmodule

//--- hdl/sample_transform.sv
// Gain, offset and saturation in one stage; in_ready is combinational from out_ready
`timescale 1ns/1ps
`include "scaler_consts.svh"

module sample_transform
	import scaler_pkg::*;
(
	input logic clock,
	input logic resetn,
	input scaler_cfg_t cfg,
	input sample_t in_data,
	input logic in_valid,
	output logic in_ready,
	output sample_t out_data,
	output logic out_valid,
	input logic out_ready,
	output logic busy
);

	// Product of sample and zero-extended gain
	localparam int PROD_W = `SAMPLE_W + `GAIN_W + 1;
	// Product after dropping the fraction bits
	localparam int SCALED_W = PROD_W - `GAIN_FRAC;
	// One more bit so the offset add cannot overflow
	localparam int SUM_W = SCALED_W + 1;

	// Clamp limits at sum width
	localparam logic signed [SUM_W-1:0] SAT_MAX = 2 ** (`SAMPLE_W - 1) - 1;
	localparam logic signed [SUM_W-1:0] SAT_MIN = -(2 ** (`SAMPLE_W - 1));

	logic signed [PROD_W-1:0] product;
	logic signed [SCALED_W-1:0] scaled;
	logic signed [SUM_W-1:0] sum;
	sample_t result;
	logic load;

	// Stage accepts when empty or being drained
	assign in_ready = !out_valid || out_ready;
	assign load = in_valid && in_ready;
	assign busy = out_valid;

	// Datapath
	always_comb
	begin
		product = in_data * $signed({1'b0, cfg.gain});
		// Dropping low bits is a floor shift
		scaled = product[PROD_W-1:`GAIN_FRAC];
		sum = scaled + cfg.offset;
		if (!cfg.enable)
			result = in_data;
		else if (sum > SAT_MAX)
			result = SAT_MAX[`SAMPLE_W-1:0];
		else if (sum < SAT_MIN)
			result = SAT_MIN[`SAMPLE_W-1:0];
		else
			result = sum[`SAMPLE_W-1:0];
	end

	// Output valid flag
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	// Result held while downstream stalls
	always_ff @(posedge clock)
	begin
		if (load)
			out_data <= result;
	end

endmodule

//--- hdl/scaler_apb_regs.sv
// APB register block without wait states or strobes; counters wrap, FILL sums occupancy
`timescale 1ns/1ps
`include "scaler_consts.svh"

module scaler_apb_regs
	import scaler_pkg::*;
(
	input logic clock,
	input logic resetn,
	input apb_req_t apb,
	output apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output scaler_cfg_t cfg,
	input logic in_fire,
	input logic out_fire,
	input occ_t in_occ,
	input occ_t out_occ,
	input logic xform_busy
);

	logic access;
	logic mapped;
	logic read_only;
	logic wr_ok;
	count_t in_count;
	count_t out_count;
	fill_t fill;

	// Access phase of a transfer
	assign access = apb.psel && apb.penable;
	// Never stretches a transfer
	assign pready = 1'b1;

	// Samples held in both skid registers and the transform stage
	assign fill = fill_t'(in_occ) + fill_t'(out_occ) + fill_t'(xform_busy);

	// Address decode
	always_comb
	begin
		mapped = 1'b1;
		read_only = 1'b0;
		prdata = '0;
		case (apb.paddr)
			`REG_CTRL: prdata = apb_data_t'(cfg.enable);
			`REG_GAIN: prdata = apb_data_t'(cfg.gain);
			`REG_OFFSET: prdata = apb_data_t'($unsigned(cfg.offset));
			`REG_IN_COUNT:
			begin
				prdata = apb_data_t'(in_count);
				read_only = 1'b1;
			end
			`REG_OUT_COUNT:
			begin
				prdata = apb_data_t'(out_count);
				read_only = 1'b1;
			end
			`REG_FILL:
			begin
				prdata = apb_data_t'(fill);
				read_only = 1'b1;
			end
			default: mapped = 1'b0;
		endcase
	end

	// Error on unmapped address or write to status
	assign pslverr = access && (!mapped || (apb.pwrite && read_only));
	assign wr_ok = access && apb.pwrite && !pslverr;

	// Configuration, updated on the edge ending the access
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			cfg.enable <= 1'b1;
			cfg.gain <= gain_t'(`RST_GAIN);
			cfg.offset <= sample_t'(`RST_OFFSET);
		end
		else if (wr_ok)
		begin
			case (apb.paddr)
				`REG_CTRL: cfg.enable <= apb.pwdata[0];
				`REG_GAIN: cfg.gain <= apb.pwdata[`GAIN_W-1:0];
				`REG_OFFSET: cfg.offset <= apb.pwdata[`SAMPLE_W-1:0];
				default: ;
			endcase
		end
	end

	// Stream transfer counters
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			in_count <= '0;
			out_count <= '0;
		end
		else
		begin
			if (in_fire)
				in_count <= in_count + 1'b1;
			if (out_fire)
				out_count <= out_count + 1'b1;
		end
	end

endmodule

//--- hdl/stream_scaler_top.sv
// Scaler top; three-cycle latency, one sample per clock, holds up to five samples
`timescale 1ns/1ps
`include "scaler_consts.svh"

module stream_scaler_top
	import scaler_pkg::*;
(
	input logic clock,
	input logic resetn,
	input sample_t in_data,
	input logic in_valid,
	output logic in_ready,
	output sample_t out_data,
	output logic out_valid,
	input logic out_ready,
	input apb_req_t apb,
	output apb_data_t prdata,
	output logic pready,
	output logic pslverr
);

	// Input register to transform
	sample_t mid_data;
	logic mid_valid;
	logic mid_ready;
	// Transform to output register
	sample_t res_data;
	logic res_valid;
	logic res_ready;
	// Status and configuration
	occ_t in_occ;
	occ_t out_occ;
	logic xform_busy;
	logic in_fire;
	logic out_fire;
	scaler_cfg_t cfg;

	// Transfers on the outer ports
	assign in_fire = in_valid && in_ready;
	assign out_fire = out_valid && out_ready;

	axis_register #(.WIDTH(`SAMPLE_W)) in_reg (
		.clock(clock), .resetn(resetn), .size(in_occ),
		.idata(in_data), .ivalid(in_valid), .iready(in_ready),
		.odata(mid_data), .ovalid(mid_valid), .oready(mid_ready)
	);

	sample_transform xform (
		.clock(clock), .resetn(resetn), .cfg(cfg),
		.in_data(mid_data), .in_valid(mid_valid), .in_ready(mid_ready),
		.out_data(res_data), .out_valid(res_valid), .out_ready(res_ready),
		.busy(xform_busy)
	);

	// Cuts the combinational ready path out of the transform
	axis_register #(.WIDTH(`SAMPLE_W)) out_reg (
		.clock(clock), .resetn(resetn), .size(out_occ),
		.idata(res_data), .ivalid(res_valid), .iready(res_ready),
		.odata(out_data), .ovalid(out_valid), .oready(out_ready)
	);

	scaler_apb_regs regs (
		.clock(clock), .resetn(resetn), .apb(apb),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .cfg(cfg),
		.in_fire(in_fire), .out_fire(out_fire),
		.in_occ(in_occ), .out_occ(out_occ), .xform_busy(xform_busy)
	);

endmodule

//--- test/stream_scaler_props.sv
// Bound into stream_scaler_top; each skid register brings its own handshake and size signals
`timescale 1ns/1ps

module stream_scaler_props
	import scaler_pkg::*;
(
	input logic clock,
	input logic resetn,
	input sample_t out_data,
	input logic out_valid,
	input logic out_ready,
	input logic pready,
	input logic in_ivalid,
	input logic in_iready,
	input logic in_ovalid,
	input logic in_oready,
	input occ_t in_size,
	input logic out_ivalid,
	input logic out_iready,
	input logic out_ovalid,
	input occ_t out_size
);

	// Failed assertions so far, polled by the testbench
	int unsigned violations = 0;

	// A stalled output beat stays put
	hold_output: assert property (@(posedge clock) disable iff (!resetn)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
	else
	begin
		$error("Output beat changed while stalled");
		violations++;
	end

	// Input skid register never full and empty at once
	// Size follows beats in minus beats out, a count of 3 never matches
	in_reg_state: assert property (@(posedge clock) disable iff (!resetn)
		(in_iready || in_ovalid)
		&& in_size == occ_t'($past(in_size) + $past(in_ivalid && in_iready)
			- $past(in_ovalid && in_oready)))
	else
	begin
		$error("Input skid register in an impossible state");
		violations++;
	end

	// Same rule for the output skid register
	out_reg_state: assert property (@(posedge clock) disable iff (!resetn)
		(out_iready || out_ovalid)
		&& out_size == occ_t'($past(out_size) + $past(out_ivalid && out_iready)
			- $past(out_ovalid && out_ready)))
	else
	begin
		$error("Output skid register in an impossible state");
		violations++;
	end

	// No wait states on APB
	no_wait: assert property (@(posedge clock) pready)
	else
	begin
		$error("pready went low");
		violations++;
	end

endmodule

//--- test/tb_stream_scaler.sv
// Config changes only on an empty pipeline; APB slave assumed to have no wait states
`timescale 1ns/1ps
`include "scaler_consts.svh"

module tb_stream_scaler
	import scaler_pkg::*;
();

	localparam int WAIT_LIMIT = 200;

	logic clock;
	logic resetn;
	sample_t in_data;
	logic in_valid;
	logic in_ready;
	sample_t out_data;
	logic out_valid;
	logic out_ready;
	apb_req_t apb;
	apb_data_t prdata;
	logic pready;
	logic pslverr;

	// Source and sink draw from separate sequences
	int seed = 62881;
	int sink_seed = 62881 + 1;
	// Configuration the model works from
	logic cur_enable;
	gain_t cur_gain;
	sample_t cur_offset;
	sample_t expect_q[$];
	// Samples accepted at the input since reset
	int accepted;
	logic beat_taken;

	stream_scaler_top uut (
		.clock(clock), .resetn(resetn),
		.in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
		.out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
		.apb(apb), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	bind stream_scaler_top stream_scaler_props props (
		.clock(clock), .resetn(resetn), .out_data(out_data), .out_valid(out_valid),
		.out_ready(out_ready), .pready(pready),
		.in_ivalid(in_valid), .in_iready(in_ready), .in_ovalid(mid_valid),
		.in_oready(mid_ready), .in_size(in_occ),
		.out_ivalid(res_valid), .out_iready(res_ready), .out_ovalid(out_valid),
		.out_size(out_occ)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#5 clock = !clock;
	end

	task automatic report_and_stop(input string line);
		$display("%s", line);
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic flag_mismatch(input string what);
		report_and_stop($sformatf("CHECK FAILED at %0t ns: %s", $time, what));
	endtask

	// Runaway guard
	initial
	begin
		#2000000;
		report_and_stop("Timeout: the run did not finish in time");
	end

	// First bound assertion failure ends the run
	always @(negedge clock)
	begin
		if (uut.props.violations != 0)
			report_and_stop("A bound assertion failed, see the error above");
	end

	// Gain multiply, floor shift, offset, clamp to 16 bits
	function automatic sample_t expected_output(input sample_t x);
		int v;
		if (!cur_enable)
			return x;
		v = (int'(x) * int'(cur_gain)) >>> `GAIN_FRAC;
		v = v + int'(cur_offset);
		if (v > 32767)
			v = 32767;
		else if (v < -32768)
			v = -32768;
		return sample_t'(v);
	endfunction

	// Setup cycle, then access cycle; sampled 1 ns after the falling edge
	task automatic bus_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
		input logic want_err, output apb_data_t rdata);
		int waits;
		@(negedge clock);
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = write;
		apb.paddr = addr;
		apb.pwdata = wdata;
		@(negedge clock);
		apb.penable = 1'b1;
		#1;
		waits = 0;
		while (!pready)
		begin
			waits++;
			assert (waits < WAIT_LIMIT)
			else report_and_stop("Timeout: APB slave never raised pready");
			@(negedge clock);
			#1;
		end
		assert (pslverr === want_err)
		else flag_mismatch($sformatf("pslverr %b at address %0h, expected %b",
			pslverr, addr, want_err));
		rdata = prdata;
		@(negedge clock);
		apb.psel = 1'b0;
		apb.penable = 1'b0;
	endtask

	task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
		apb_data_t unused;
		bus_access(1'b1, addr, data, 1'b0, unused);
	endtask

	task automatic check_reg(input apb_addr_t addr, input apb_data_t want, input string name);
		apb_data_t got;
		bus_access(1'b0, addr, '0, 1'b0, got);
		assert (got === want)
		else flag_mismatch($sformatf("%s read %0h, expected %0h", name, got, want));
	endtask

	// Counters match everything sent, pipeline empty
	task automatic check_all_regs();
		check_reg(`REG_CTRL, apb_data_t'(cur_enable), "CTRL");
		check_reg(`REG_GAIN, apb_data_t'(cur_gain), "GAIN");
		check_reg(`REG_OFFSET, {16'h0, cur_offset}, "OFFSET");
		check_reg(`REG_IN_COUNT, apb_data_t'(accepted), "IN_COUNT");
		check_reg(`REG_OUT_COUNT, apb_data_t'(accepted), "OUT_COUNT");
		check_reg(`REG_FILL, '0, "FILL");
	endtask

	task automatic set_config(input logic enable, input gain_t gain, input sample_t offset);
		write_reg(`REG_CTRL, apb_data_t'(enable));
		write_reg(`REG_GAIN, apb_data_t'(gain));
		write_reg(`REG_OFFSET, {16'h0, offset});
		cur_enable = enable;
		cur_gain = gain;
		cur_offset = offset;
	endtask

	// Poll FILL until the pipeline is empty
	task automatic wait_drained();
		apb_data_t fill;
		int tries;
		tries = 0;
		bus_access(1'b0, `REG_FILL, '0, 1'b0, fill);
		while (fill != 0)
		begin
			tries++;
			assert (tries < WAIT_LIMIT)
			else report_and_stop("Timeout: pipeline never drained");
			bus_access(1'b0, `REG_FILL, '0, 1'b0, fill);
		end
	endtask

	// One falling edge of the source
	task automatic offer_step(input logic gaps);
		// Beat went through on the last rising edge
		if (beat_taken)
			in_valid = 1'b0;
		beat_taken = 1'b0;
		if (!in_valid && (!gaps || ($random(seed) & 3) != 0))
		begin
			in_data = sample_t'($random(seed));
			in_valid = 1'b1;
		end
		// in_ready is registered, holds until the next rising edge
		if (in_valid && in_ready)
		begin
			expect_q.push_back(expected_output(in_data));
			beat_taken = 1'b1;
			accepted++;
		end
	endtask

	task automatic send_samples(input int n, input logic gaps);
		int target;
		int idle;
		target = accepted + n;
		idle = 0;
		while (accepted < target)
		begin
			@(negedge clock);
			offer_step(gaps);
			idle = beat_taken ? 0 : idle + 1;
			assert (idle < WAIT_LIMIT)
			else report_and_stop("Timeout: input never accepted a sample");
		end
		@(negedge clock);
		in_valid = 1'b0;
		beat_taken = 1'b0;
	endtask

	task automatic receive_samples(input int n);
		int got;
		int idle;
		logic rdy;
		sample_t want;
		got = 0;
		idle = 0;
		while (got < n)
		begin
			@(negedge clock);
			rdy = ($random(sink_seed) & 3) != 0;
			out_ready = rdy;
			// Output settled at the last rising edge
			if (out_valid && rdy)
			begin
				assert (expect_q.size() > 0)
				else flag_mismatch("output beat with no sample expected");
				want = expect_q.pop_front();
				assert (out_data === want)
				else flag_mismatch($sformatf("output %0d, expected %0d", out_data, want));
				got++;
				idle = 0;
			end
			else
			begin
				idle++;
				assert (idle < WAIT_LIMIT)
				else report_and_stop("Timeout: no output sample arrived");
			end
		end
		@(negedge clock);
		out_ready = 1'b0;
	endtask

	task automatic run_burst(input int n);
		fork
			send_samples(n, 1'b1);
			receive_samples(n);
		join
		wait_drained();
		check_all_regs();
	endtask

	initial
	begin
		int base;
		resetn = 1'b0;
		in_data = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		apb = '0;
		accepted = 0;
		beat_taken = 1'b0;
		cur_enable = 1'b1;
		cur_gain = gain_t'(`RST_GAIN);
		cur_offset = sample_t'(`RST_OFFSET);
		repeat (8) @(posedge clock);
		@(negedge clock);
		resetn = 1'b1;

		// Reset values
		assert (out_valid === 1'b0)
		else flag_mismatch("out_valid high after reset");
		check_all_regs();

		// Bypass keeps samples unchanged
		set_config(1'b0, gain_t'(`RST_GAIN), '0);
		run_burst(40);

		// Scaling, first two rounds push past both limits
		for (int r = 0; r < 6; r++)
		begin
			if (r == 0)
				set_config(1'b1, 8'hFF, 16'sh7000);
			else if (r == 1)
				set_config(1'b1, 8'hFF, -16'sh7000);
			else
				set_config(1'b1, gain_t'($random(seed)), sample_t'($random(seed)));
			run_burst(30);
		end

		// Sink held off, five samples fill the pipeline
		set_config(1'b1, 8'd24, 16'sd100);
		base = accepted;
		repeat (20)
		begin
			@(negedge clock);
			offer_step(1'b0);
		end
		assert (accepted - base == 5 && in_ready === 1'b0)
		else flag_mismatch($sformatf("%0d samples accepted under stall", accepted - base));
		check_reg(`REG_FILL, 32'd5, "FILL under stall");
		// Sixth sample still pending behind the five
		fork
			send_samples(1, 1'b0);
			receive_samples(6);
		join
		wait_drained();
		check_all_regs();

		// Bad accesses change nothing
		begin
			apb_data_t unused;
			bus_access(1'b1, 8'h18, 32'hFFFF_FFFF, 1'b1, unused);
			bus_access(1'b0, 8'h40, '0, 1'b1, unused);
			bus_access(1'b1, `REG_IN_COUNT, 32'h1234, 1'b1, unused);
		end
		check_all_regs();

		if (uut.props.violations == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
			report_and_stop("Bound assertions failed during the run");
	end

endmodule

//--- src.f
+incdir+hdl
hdl/scaler_pkg.sv
hdl/axis_register.sv
hdl/sample_transform.sv
hdl/scaler_apb_regs.sv
hdl/stream_scaler_top.sv
test/stream_scaler_props.sv
test/tb_stream_scaler.sv

//--- Bender.yml
package:
  name: stream_scaler

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/scaler_pkg.sv
      - hdl/axis_register.sv
      - hdl/sample_transform.sv
      - hdl/scaler_apb_regs.sv
      - hdl/stream_scaler_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/stream_scaler_props.sv
      - test/tb_stream_scaler.sv
